// File: pce_io_cases.txt
# name kind joy_a joy_b joy_2 joy_3 joy_4 flags clears sels sel mouse_x mouse_y expect
# flags: 0 swap, 1 turbotap, 2 buttons6, 3 mouse_en, 4 left, 5 right; audio_sat: psg cdda adpcm
reset_state     reset      000   000   000  000 000 00 0  0 1 00 00 0
pad_dirs        pad        0A5   000   000  000 000 00 1  0 1 00 00 9
pad_main        pad        0A5   000   000  000 000 00 1  0 0 00 00 5
swap_dirs       pad        0A5   05A   000  000 000 01 1  0 1 00 00 6
tap_port1       pad        0A5   05A   00F  0F0 0C3 02 1  1 1 00 00 6
tap_port2_main  pad        0A5   05A   00F  0F0 0C3 02 1  2 0 00 00 F
tap_port3       pad        0A5   05A   00F  0F0 0C3 02 1  3 1 00 00 F
tap_port4       pad        0A5   05A   00F  0F0 0C3 02 1  4 1 00 00 5
tap_idle        pad        0A5   05A   00F  0F0 0C3 02 1  5 1 00 00 F
tap_off         pad        0A5   05A   00F  0F0 0C3 00 1  3 1 00 00 9
six_extra       pad        5A5   000   000  000 000 04 1  0 0 00 00 A
six_zero        pad        5A5   000   000  000 000 04 1  0 1 00 00 0
six_back        pad        5A5   000   000  000 000 04 2  0 1 00 00 9
mouse_early     mouse      000   000   000  000 000 08 3  0 1 13 7C 0
mouse_x_hi      mouse      000   000   000  000 000 08 4  0 1 13 7C E
mouse_x_lo      mouse      000   000   000  000 000 08 5  0 1 13 7C D
mouse_y_hi      mouse      000   000   000  000 000 08 6  0 1 13 7C 7
mouse_y_lo      mouse      000   000   000  000 000 08 7  0 1 13 7C C
mouse_buttons   mouse      000   000   000  000 000 18 4  0 0 13 7C D
mouse_timeout   timeout    000   000   000  000 000 08 1  0 1 13 7C E
audio_random    audio_rand 00000 00000 0000 000 000 00 24 0 1 00 00 auto
audio_pos_rail  audio_sat  7FFFF 7FFFF 0000 000 000 00 0  0 1 00 00 auto
audio_edge      audio_sat  40000 3FFFF 0000 000 000 00 0  0 1 00 00 auto
audio_overflow  audio_sat  7FFF0 00000 0001 000 000 00 0  0 1 00 00 auto
audio_adpcm_min audio_sat  00000 00000 8000 000 000 00 0  0 1 00 00 auto

// File: sources.f
pce_io_pkg.sv
pad_scan_if.sv
pad_scan_ctrl.sv
pad_nibble_mux.sv
mouse_tracker.sv
audio_mixer.sv
pce_io_top.sv
tb_pce_io.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_pce_io
FILELIST  := sources.f
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_pce_io.sv
// Self-checking testbench for the console input and audio top level
// Reads pce_io_cases.txt and checks joy_in and the mixer outputs
module tb_pce_io;
	import pce_io_pkg::*;

	localparam int MOUSE_TIMEOUT_BITS = 6;
	localparam int CYCLE_BUDGET       = 200;                         // Watchdog cycles per case
	localparam int TIMEOUT_WAIT       = 2 ** MOUSE_TIMEOUT_BITS + 16; // Past the mouse timeout

	logic          clk_sys = 1'b0;
	logic          arst_n;
	logic [1:0]    joy_out;
	logic [3:0]    joy_in;
	pad_bits_t     joy_a;
	pad_bits_t     joy_b;
	pad_bits_t     joy_2;
	pad_bits_t     joy_3;
	pad_bits_t     joy_4;
	logic          joy_swap;
	logic          turbotap;
	logic          buttons6;
	logic          mouse_en;
	logic [7:0]    mouse_x;
	logic [7:0]    mouse_y;
	logic [1:0]    mouse_btn;
	logic          mouse_strobe;
	audio_sample_t psg_l;
	audio_sample_t psg_r;
	audio_sample_t cdda_l;
	audio_sample_t cdda_r;
	adpcm_sample_t adpcm;
	dac_word_t     audio_l;
	dac_word_t     audio_r;

	string lines [$];          // Raw case records
	bit    cases_loaded = 1'b0;
	int    passes = 0;
	int    errors = 0;

	always #2 clk_sys = ~clk_sys;

	pce_io_top #(
		.MOUSE_TIMEOUT_BITS(MOUSE_TIMEOUT_BITS)
	) pce_io_top_inst (
		.clk_sys(clk_sys), .arst_n(arst_n), .joy_out(joy_out), .joy_in(joy_in),
		.joy_a(joy_a), .joy_b(joy_b), .joy_2(joy_2), .joy_3(joy_3), .joy_4(joy_4),
		.joy_swap(joy_swap), .turbotap(turbotap), .buttons6(buttons6), .mouse_en(mouse_en),
		.mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_btn(mouse_btn),
		.mouse_strobe(mouse_strobe), .psg_l(psg_l), .psg_r(psg_r), .cdda_l(cdda_l),
		.cdda_r(cdda_r), .adpcm(adpcm), .audio_l(audio_l), .audio_r(audio_r)
	);

	// ==================================================
	// Stimulus helpers
	// ==================================================

	task automatic idle_inputs();
		arst_n       <= 1'b0;
		joy_out      <= 2'b01; // Select high, clear low
		joy_a        <= '0;
		joy_b        <= '0;
		joy_2        <= '0;
		joy_3        <= '0;
		joy_4        <= '0;
		joy_swap     <= 1'b0;
		turbotap     <= 1'b0;
		buttons6     <= 1'b0;
		mouse_en     <= 1'b0;
		mouse_x      <= '0;
		mouse_y      <= '0;
		mouse_btn    <= '0;
		mouse_strobe <= 1'b0;
		psg_l        <= '0;
		psg_r        <= '0;
		cdda_l       <= '0;
		cdda_r       <= '0;
		adpcm        <= '0;
	endtask

	task automatic pulse_clear();
		joy_out[1] <= 1'b1;
		repeat (2) @(posedge clk_sys);
		joy_out[1] <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic pulse_select();
		joy_out[0] <= 1'b0;
		repeat (2) @(posedge clk_sys);
		joy_out[0] <= 1'b1; // One rising edge per pulse
		repeat (2) @(posedge clk_sys);
	endtask

	// Offset binary with clamp at the 20-bit signed limits
	function automatic logic [19:0] expected_dac(input int sum);
		if (sum > 524287)
			return 20'hFFFFF;
		else if (sum < -524288)
			return 20'h00000;
		else
			return 20'(sum + 524288);
	endfunction

	// Right side gets the negated PSG and CD samples
	task automatic mix_vector(input audio_sample_t p, input audio_sample_t c,
		input adpcm_sample_t a, output logic [39:0] exp_v, output logic [39:0] act_v);
		audio_sample_t p_neg;
		audio_sample_t c_neg;
		p_neg = -p;
		c_neg = -c;
		psg_l  <= p;
		cdda_l <= c;
		psg_r  <= p_neg;
		cdda_r <= c_neg;
		adpcm  <= a;
		@(posedge clk_sys); // Mixer registers here
		@(negedge clk_sys);
		exp_v = {expected_dac(int'(p) + int'(c) + 16 * int'(a)),
			expected_dac(int'(p_neg) + int'(c_neg) + 16 * int'(a))};
		act_v = {audio_l, audio_r};
		@(posedge clk_sys);
	endtask

	task automatic report_result(input string name, input logic [47:0] exp_v,
		input logic [47:0] act_v);
		if (exp_v === act_v) begin
			passes++;
			$display("PASS %s", name);
		end else begin
			errors++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp_v, act_v);
		end
	endtask

	// ==================================================
	// Case handling
	// ==================================================

	task automatic load_cases();
		int    fd;
		string line;
		fd = $fopen("pce_io_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the cases file pce_io_cases.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
	endtask

	task automatic run_case(input string line);
		string       name;
		string       kind;
		string       exp_str;
		logic [19:0] op_a;
		logic [19:0] op_b;
		logic [19:0] op_c;
		logic [19:0] op_d;
		logic [19:0] op_e;
		logic [7:0]  flags;
		logic [7:0]  mx;
		logic [7:0]  my;
		logic [19:0] exp_val;
		logic [39:0] exp_v;
		logic [39:0] act_v;
		int          clears;
		int          sels;
		int          sel_level;
		int          n;
		int          i;
		n = $sscanf(line, "%s %s %h %h %h %h %h %h %d %d %d %h %h %s", name, kind, op_a,
			op_b, op_c, op_d, op_e, flags, clears, sels, sel_level, mx, my, exp_str);
		if (n != 14) begin
			errors++;
			$display("Malformed case record: %s", line);
			return;
		end
		exp_val = '0;
		if (exp_str != "auto")
			void'($sscanf(exp_str, "%h", exp_val));

		@(posedge clk_sys);
		idle_inputs();
		repeat (16) @(posedge clk_sys);
		if (kind == "reset") begin
			@(negedge clk_sys); // Still inside reset
			report_result(name, {4'h0, exp_val[3:0], 20'h80000, 20'h80000},
				{4'h0, joy_in, audio_l, audio_r});
		end
		@(posedge clk_sys);
		arst_n    <= 1'b1;
		joy_a     <= op_a[11:0];
		joy_b     <= op_b[11:0];
		joy_2     <= op_c[11:0];
		joy_3     <= op_d[11:0];
		joy_4     <= op_e[11:0];
		joy_swap  <= flags[0];
		turbotap  <= flags[1];
		buttons6  <= flags[2];
		mouse_en  <= flags[3];
		mouse_btn <= flags[5:4];
		mouse_x   <= mx;
		mouse_y   <= my;

		if (kind == "audio_rand" || kind == "audio_sat") begin
			i     = 0;
			exp_v = '0;
			act_v = '0;
			while (i < ((kind == "audio_sat") ? 1 : clears) && exp_v === act_v) begin
				if (kind == "audio_sat")
					mix_vector(op_a, op_b, op_c[15:0], exp_v, act_v);
				else
					mix_vector(audio_sample_t'($urandom()), audio_sample_t'($urandom()),
						adpcm_sample_t'($urandom()), exp_v, act_v);
				i++;
			end
			report_result(name, {8'h0, exp_v}, {8'h0, act_v});
		end else if (kind == "pad" || kind == "mouse" || kind == "timeout") begin
			if (kind != "pad") begin
				mouse_strobe <= 1'b1;
				@(posedge clk_sys);
				mouse_strobe <= 1'b0;
				@(posedge clk_sys);
			end
			if (kind == "timeout")
				repeat (TIMEOUT_WAIT) @(posedge clk_sys); // Clear held low
			repeat (clears) pulse_clear();
			repeat (sels) pulse_select();
			joy_out[0] <= sel_level[0];
			repeat (4) @(posedge clk_sys);
			@(negedge clk_sys);
			report_result(name, {44'h0, exp_val[3:0]}, {44'h0, joy_in});
		end else if (kind != "reset") begin
			errors++;
			$display("Unknown test kind %s in case %s", kind, name);
		end
	endtask

	initial begin
		void'($urandom(74331));
		idle_inputs();
		load_cases();
		cases_loaded = 1'b1;
		foreach (lines[k])
			run_case(lines[k]);
		$display("Tests: %0d passed, %0d failed", passes, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog scaled by the number of cases
	initial begin
		wait (cases_loaded);
		repeat ((lines.size() + 1) * CYCLE_BUDGET) @(posedge clk_sys);
		$display("Timeout: the tests did not complete within the cycle budget");
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: pce_io_top.sv
// Console-side input and audio top level
// Port scanner with pad and mouse datapaths, plus the audio mixer
module pce_io_top #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,

	// Controller port
	input  logic [1:0]                joy_out,    // [0] select, [1] clear
	output logic [3:0]                joy_in,
	input  pce_io_pkg::pad_bits_t     joy_a,
	input  pce_io_pkg::pad_bits_t     joy_b,
	input  pce_io_pkg::pad_bits_t     joy_2,
	input  pce_io_pkg::pad_bits_t     joy_3,
	input  pce_io_pkg::pad_bits_t     joy_4,
	input  logic                      joy_swap,
	input  logic                      turbotap,
	input  logic                      buttons6,
	input  logic                      mouse_en,

	// Mouse
	input  logic [7:0]                mouse_x,
	input  logic [7:0]                mouse_y,
	input  logic [1:0]                mouse_btn,
	input  logic                      mouse_strobe,

	// Audio
	input  pce_io_pkg::audio_sample_t psg_l,
	input  pce_io_pkg::audio_sample_t psg_r,
	input  pce_io_pkg::audio_sample_t cdda_l,
	input  pce_io_pkg::audio_sample_t cdda_r,
	input  pce_io_pkg::adpcm_sample_t adpcm,
	output pce_io_pkg::dac_word_t     audio_l,
	output pce_io_pkg::dac_word_t     audio_r
);

	pad_scan_if scan_if ();

	logic [7:0] mouse_byte;
	logic [1:0] run_select;

	// Run and select of whichever pad lands on port 0
	assign run_select = joy_swap ? joy_b[7:6] : joy_a[7:6];

	pad_scan_ctrl #(
		.MOUSE_TIMEOUT_BITS(MOUSE_TIMEOUT_BITS)
	) pad_scan_ctrl_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.pad_sel (joy_out[0]),
		.pad_clr (joy_out[1]),
		.turbotap(turbotap),
		.buttons6(buttons6),
		.scan    (scan_if.ctrl)
	);

	pad_nibble_mux pad_nibble_mux_inst (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.joy_a     (joy_a),
		.joy_b     (joy_b),
		.joy_2     (joy_2),
		.joy_3     (joy_3),
		.joy_4     (joy_4),
		.joy_swap  (joy_swap),
		.mouse_en  (mouse_en),
		.mouse_byte(mouse_byte),
		.scan      (scan_if.pad),
		.joy_in    (joy_in)
	);

	mouse_tracker mouse_tracker_inst (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.mouse_x     (mouse_x),
		.mouse_y     (mouse_y),
		.mouse_btn   (mouse_btn),
		.mouse_strobe(mouse_strobe),
		.run_select  (run_select),
		.scan        (scan_if.mouse),
		.mouse_byte  (mouse_byte)
	);

	audio_mixer audio_mixer_inst (
		.clk_sys(clk_sys),
		.arst_n (arst_n),
		.psg_l  (psg_l),
		.psg_r  (psg_r),
		.cdda_l (cdda_l),
		.cdda_r (cdda_r),
		.adpcm  (adpcm),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

endmodule

// File: audio_mixer.sv
// Three-source audio mixer with saturation to an offset-binary DAC word
module audio_mixer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  pce_io_pkg::audio_sample_t psg_l,
	input  pce_io_pkg::audio_sample_t psg_r,
	input  pce_io_pkg::audio_sample_t cdda_l,
	input  pce_io_pkg::audio_sample_t cdda_r,
	input  pce_io_pkg::adpcm_sample_t adpcm,
	output pce_io_pkg::dac_word_t     audio_l,
	output pce_io_pkg::dac_word_t     audio_r
);
	import pce_io_pkg::*;

	mix_sum_t sum_l;
	mix_sum_t sum_r;
	mix_sum_t adpcm_ext;

	// ADPCM is mono and sits 4 bits up in the 20-bit range
	assign adpcm_ext = mix_sum_t'(adpcm) <<< 4;

	// Sign flip when in range, rail otherwise
	function automatic dac_word_t clamp(input mix_sum_t s);
		if (s[21:19] == 3'b000 || s[21:19] == 3'b111)
			return {~s[19], s[18:0]};
		else if (s[21])
			return 20'h00000; // Negative overflow
		else
			return 20'hFFFFF;
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= mix_sum_t'(psg_l) + mix_sum_t'(cdda_l) + adpcm_ext;
			sum_r <= mix_sum_t'(psg_r) + mix_sum_t'(cdda_r) + adpcm_ext;
		end
	end

	assign audio_l = clamp(sum_l);
	assign audio_r = clamp(sum_r);

endmodule

// File: mouse_tracker.sv
// Mouse motion capture and the phase-served mouse byte
module mouse_tracker (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [7:0] mouse_x,
	input  logic [7:0] mouse_y,
	input  logic [1:0] mouse_btn,    // Bit 0 left
	input  logic       mouse_strobe,
	input  logic [1:0] run_select,   // Pad 0 after swap, {run, select}
	pad_scan_if.mouse  scan,
	output logic [7:0] mouse_byte
);

	logic [7:0] held_x;   // Collected since the last transfer
	logic [7:0] held_y;
	logic [7:0] served_x; // Frozen for the current frame
	logic [7:0] served_y;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			held_x   <= 8'h00;
			held_y   <= 8'h00;
			served_x <= 8'h00;
			served_y <= 8'h00;
		end else begin
			if (scan.mouse_transfer) begin
				served_x <= held_x;
				served_y <= held_y;
				held_x   <= 8'h00;
				held_y   <= 8'h00;
			end
			// A new sample in the same clock overrides the clear
			if (mouse_strobe) begin
				held_x <= 8'h00 - mouse_x; // Console x axis runs the other way
				held_y <= mouse_y;
			end
		end
	end

	// Button nibble, active low
	assign mouse_byte[3:0] = ~{run_select, mouse_btn[0], mouse_btn[1]};

	always_comb begin
		case (scan.mouse_phase)
			2'd0:    mouse_byte[7:4] = served_x[7:4];
			2'd1:    mouse_byte[7:4] = served_x[3:0];
			2'd2:    mouse_byte[7:4] = served_y[7:4];
			default: mouse_byte[7:4] = served_y[3:0];
		endcase
	end

endmodule

// File: pad_nibble_mux.sv
// Per-port word build, nibble select and the registered joy_in latch
module pad_nibble_mux (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  pce_io_pkg::pad_bits_t joy_a,
	input  pce_io_pkg::pad_bits_t joy_b,
	input  pce_io_pkg::pad_bits_t joy_2,
	input  pce_io_pkg::pad_bits_t joy_3,
	input  pce_io_pkg::pad_bits_t joy_4,
	input  logic                  joy_swap,
	input  logic                  mouse_en,
	input  logic [7:0]            mouse_byte,
	pad_scan_if.pad               scan,
	output logic [3:0]            joy_in
);
	import pce_io_pkg::*;

	// ==================================================
	// Port word build
	// ==================================================

	// Console side is active low
	function automatic pad_word_u build_word(input pad_bits_t p);
		pad_word_u w;
		w.f.unused = 4'h0;
		w.f.extra  = ~p[11:8];
		w.f.dirs   = ~{p[1], p[2], p[0], p[3]}; // Left, down, right, up
		w.f.main   = ~p[7:4];
		return w;
	endfunction

	pad_bits_t pads [NUM_PORTS];
	pad_word_u port_word;

	always_comb begin
		pads[0] = joy_swap ? joy_b : joy_a;
		pads[1] = joy_swap ? joy_a : joy_b;
		pads[2] = joy_2;
		pads[3] = joy_3;
		pads[4] = joy_4;
	end

	always_comb begin
		if (scan.port_index >= port_idx_t'(NUM_PORTS))
			port_word = IDLE_PORT_WORD;
		else if (scan.port_index == '0 && mouse_en)
			port_word = {mouse_byte, mouse_byte}; // Same byte in both banks
		else
			port_word = build_word(pads[scan.port_index]);
	end

	// ==================================================
	// Output latch
	// ==================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joy_in <= 4'h0;
		end else if (scan.clear) begin
			joy_in <= 4'h0;
		end else begin
			joy_in <= port_word.nib[scan.nibble_index];
		end
	end

endmodule

// File: pad_scan_ctrl.sv
// Port scanner: select and clear edges, multitap port, button bank, mouse phase
module pad_scan_ctrl #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     pad_sel,
	input  logic     pad_clr,
	input  logic     turbotap,
	input  logic     buttons6,
	pad_scan_if.ctrl scan
);
	import pce_io_pkg::*;

	logic [1:0] sel_q; // [0] sampled, [1] one clock older
	logic [1:0] clr_q;
	logic       sel_rise;
	logic       clr_rise;

	port_idx_t    port_q;
	logic         bank_q;     // Second button bank on six-button pads
	mouse_phase_t phase_q;
	logic         transfer_q;

	logic [MOUSE_TIMEOUT_BITS-1:0] timeout_q;
	logic                          timeout_done;

	assign sel_rise     = sel_q[0] & ~sel_q[1];
	assign clr_rise     = clr_q[0] & ~clr_q[1];
	assign timeout_done = &timeout_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sel_q      <= '0;
			clr_q      <= '0;
			port_q     <= '0;
			bank_q     <= 1'b0;
			phase_q    <= '0;
			transfer_q <= 1'b0;
			timeout_q  <= '0;
		end else begin
			sel_q <= {sel_q[0], pad_sel};
			clr_q <= {clr_q[0], pad_clr};

			// Multitap stepping
			if (clr_rise) begin
				port_q <= '0;
				bank_q <= ~bank_q & buttons6; // Toggles only with six buttons
			end else if (sel_rise && !clr_q[0] && turbotap) begin
				port_q <= port_q + port_idx_t'(1);
			end

			// Mouse idle timeout runs only while clear is low
			if (clr_q[0])
				timeout_q <= '0;
			else if (!timeout_done)
				timeout_q <= timeout_q + MOUSE_TIMEOUT_BITS'(1);

			// A clear edge wins over the timeout
			if (clr_rise)
				phase_q <= phase_q + mouse_phase_t'(1);
			else if (timeout_done)
				phase_q <= mouse_phase_t'(3);

			transfer_q <= clr_rise && (phase_q == mouse_phase_t'(3)); // Frame wrap
		end
	end

	assign scan.port_index     = port_q;
	assign scan.nibble_index   = {bank_q, sel_q[0]};
	assign scan.clear          = clr_q[0];
	assign scan.mouse_phase    = phase_q;
	assign scan.mouse_transfer = transfer_q;

endmodule

// File: pad_scan_if.sv
// Scan state bundle from the port scanner to the pad and mouse datapaths
interface pad_scan_if;
	import pce_io_pkg::*;

	port_idx_t    port_index;     // Current multitap port
	nibble_idx_t  nibble_index;   // Bank bit above select bit
	logic         clear;          // Console holds clear
	mouse_phase_t mouse_phase;
	logic         mouse_transfer; // Single cycle

	modport ctrl (
		output port_index,
		output nibble_index,
		output clear,
		output mouse_phase,
		output mouse_transfer
	);

	modport pad (
		input port_index,
		input nibble_index,
		input clear
	);

	modport mouse (
		input mouse_phase,
		input mouse_transfer
	);

endinterface

// File: pce_io_pkg.sv
// Shared types and constants for the console input and audio logic
// Pad bit layout, scan indices, port word union and audio sample widths
package pce_io_pkg;

	// ==================================================
	// Controller side
	// ==================================================

	// Host pad word, active high
	// 0 right, 1 left, 2 down, 3 up, 4 I, 5 II, 6 select, 7 run, 8..11 III..VI
	typedef logic [11:0] pad_bits_t;

	typedef logic [2:0] port_idx_t;    // Multitap port number
	typedef logic [1:0] nibble_idx_t;  // {bank, select}
	typedef logic [1:0] mouse_phase_t; // Motion nibble served by the mouse

	// Field view of a port word, low nibble first on the wire
	typedef struct packed {
		logic [3:0] unused; // Always reads 0
		logic [3:0] extra;  // Buttons VI..III
		logic [3:0] dirs;   // Left, down, right, up
		logic [3:0] main;   // Run, select, II, I
	} pad_fields_t;

	// Same 16 bits seen as four nibbles picked by nibble_idx_t
	typedef union packed {
		pad_fields_t     f;
		logic [3:0][3:0] nib;
	} pad_word_u;

	localparam int NUM_PORTS = 5;
	localparam logic [15:0] IDLE_PORT_WORD = 16'h0FFF; // Port past the last one

	// ==================================================
	// Audio side
	// ==================================================

	typedef logic signed [19:0] audio_sample_t; // PSG and CD audio
	typedef logic signed [15:0] adpcm_sample_t;
	typedef logic signed [21:0] mix_sum_t;      // Headroom for three sources
	typedef logic [19:0] dac_word_t;            // Offset binary

endpackage
